// ==== vlog.f ====
+incdir+include
hdl/cnn_layer_pkg.sv
hdl/fp16_pkg.sv
hdl/pool_layer_ctrl.sv
hdl/pool_window_counter.sv
hdl/fm_pingpong_ram.sv
hdl/max_pool_lanes.sv
hdl/cnn_pool_layer.sv
verification/tb_cnn_pool_layer.sv

// ==== Bender.yml ====
package:
  name: cnn_pool_layer

sources:
  - include_dirs:
      - include
    files:
      - hdl/cnn_layer_pkg.sv
      - hdl/fp16_pkg.sv
      - hdl/pool_layer_ctrl.sv
      - hdl/pool_window_counter.sv
      - hdl/fm_pingpong_ram.sv
      - hdl/max_pool_lanes.sv
      - hdl/cnn_pool_layer.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_cnn_pool_layer.sv

// ==== verification/tb_cnn_pool_layer.sv ====
`timescale 1ns/1ps

`include "cnn_params.svh"

module tb_cnn_pool_layer;

	localparam int WAIT_LIMIT = 2000;

	logic                             clk;
	logic                             rst;
	cnn_layer_pkg::layer_type_e       layer_type;
	logic [`CNN_LAYER_NUM_WIDTH-1:0]  layer_num;
	logic [`CNN_FM_SIZE_WIDTH-1:0]    fm_size;
	logic [`CNN_POOL_SIZE_WIDTH-1:0]  pool_k;
	logic                             init_we;
	logic [`CNN_ADDR_WIDTH-1:0]       init_addr;
	fp16_pkg::fp16_lanes_t            init_data;
	logic                             init_done;
	logic                             rd_en;
	logic [`CNN_ADDR_WIDTH-1:0]       rd_addr;
	fp16_pkg::fp16_lanes_t            rd_data;
	logic                             init_fm_ram_ready;
	logic                             layer_ready;
	logic                             fm_bank;

	// Model of the current input half and of the last pool result
	fp16_pkg::fp16_lanes_t model_fm [0:`CNN_FM_RAM_HALF-1];
	fp16_pkg::fp16_lanes_t expect_fm [0:`CNN_FM_RAM_HALF-1];

	// Words expected on the readback port in issue order
	fp16_pkg::fp16_lanes_t exp_q [$];
	int                    addr_q [$];
	fp16_pkg::fp16_lanes_t exp_word;
	int                    exp_addr;
	logic                  rd_seen = 1'b0;

	integer seed;
	int     errors;
	int     tests_run;
	int     tests_failed;
	int     err_start;
	logic   exp_bank;
	int     last_num;

	cnn_pool_layer u_cnn_pool_layer (
		.clk                 (clk),
		.rst                 (rst),
		.layer_type_i        (layer_type),
		.layer_num_i         (layer_num),
		.fm_size_i           (fm_size),
		.pool_win_size_i     (pool_k),
		.init_we_i           (init_we),
		.init_addr_i         (init_addr),
		.init_data_i         (init_data),
		.init_done_i         (init_done),
		.rd_en_i             (rd_en),
		.rd_addr_i           (rd_addr),
		.rd_data_o           (rd_data),
		.init_fm_ram_ready_o (init_fm_ram_ready),
		.layer_ready_o       (layer_ready),
		.fm_bank_o           (fm_bank)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Sortable key with positives above negatives and -0 just below +0
	function automatic logic [15:0] order_key(input fp16_pkg::fp16_t v);
		return v[15] ? {1'b0, ~v[14:0]} : {1'b1, v[14:0]};
	endfunction

	// Expected output word of one non-overlapping k x k window
	function automatic fp16_pkg::fp16_lanes_t pool_ref(input int side, input int k,
		input int out_idx);
		int                    out_side;
		int                    base;
		fp16_pkg::fp16_t       v;
		fp16_pkg::fp16_lanes_t best;
		out_side = side / k;
		base     = (out_idx / out_side) * k * side + (out_idx % out_side) * k;
		best     = model_fm[base];
		for (int r = 0; r < k; r++) begin
			for (int c = 0; c < k; c++) begin
				for (int j = 0; j < `CNN_PARA_Y; j++) begin
					v = model_fm[base + r * side + c][j];
					if (order_key(v) > order_key(best[j])) begin
						best[j] = v;
					end
				end
			end
		end
		return best;
	endfunction

	function automatic logic status_bit(input int sel);
		return (sel == 0) ? init_fm_ram_ready : layer_ready;
	endfunction

	// Finite float16 only with exponent 31 folded to 30
	task automatic random_word(output fp16_pkg::fp16_lanes_t w);
		logic [31:0] r;
		logic [4:0]  e;
		for (int j = 0; j < `CNN_PARA_Y; j++) begin
			r    = $random(seed);
			e    = (r[14:10] == 5'd31) ? 5'd30 : r[14:10];
			w[j] = {r[15], e, r[9:0]};
		end
	endtask

	task automatic wait_status(input int sel, input logic level, input string what);
		int cnt;
		cnt = 0;
		while (status_bit(sel) !== level && cnt < WAIT_LIMIT) begin
			@(negedge clk);
			cnt++;
		end
		if (status_bit(sel) !== level) begin
			$display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
			$display("** FAIL **");
			$finish;
		end
	endtask

	// Host fills the current half with a random side x side map
	task automatic load_fm(input int side);
		fp16_pkg::fp16_lanes_t w;
		layer_type = cnn_layer_pkg::INIT;
		@(negedge clk);
		for (int i = 0; i < side * side; i++) begin
			random_word(w);
			model_fm[i] = w;
			init_we     = 1'b1;
			init_addr   = i[`CNN_ADDR_WIDTH-1:0];
			init_data   = w;
			@(negedge clk);
		end
		init_we   = 1'b0;
		init_done = 1'b1;
		wait_status(0, 1'b1, "init_fm_ram_ready_o to rise");
		// Layer ready trails by one edge
		if (layer_ready !== 1'b0) begin
			$display("mismatch at %0t: layer_ready_o rose with init_fm_ram_ready_o", $time);
			errors++;
		end
		wait_status(1, 1'b1, "layer_ready_o after init");
		init_done = 1'b0;
		// Park on POOL with the stored number so nothing starts
		layer_type = cnn_layer_pkg::POOL;
		layer_num  = last_num[`CNN_LAYER_NUM_WIDTH-1:0];
		@(negedge clk);
	endtask

	task automatic run_pool(input int num, input int side, input int k);
		int n;
		n          = (side / k) * (side / k);
		fm_size    = side[`CNN_FM_SIZE_WIDTH-1:0];
		pool_k     = k[`CNN_POOL_SIZE_WIDTH-1:0];
		layer_num  = num[`CNN_LAYER_NUM_WIDTH-1:0];
		layer_type = cnn_layer_pkg::POOL;
		last_num   = num;
		wait_status(1, 1'b0, "layer_ready_o to drop at pool start");
		wait_status(1, 1'b1, "layer_ready_o at pool end");
		exp_bank = ~exp_bank;
		if (fm_bank !== exp_bank) begin
			$display("mismatch at %0t: fm_bank_o is %b, expected %b",
				$time, fm_bank, exp_bank);
			errors++;
		end
		for (int i = 0; i < n; i++) begin
			expect_fm[i] = pool_ref(side, k, i);
		end
		// Result half is the next layer's input
		for (int i = 0; i < n; i++) begin
			model_fm[i] = expect_fm[i];
		end
	endtask

	task automatic readback(input int count);
		for (int i = 0; i < count; i++) begin
			rd_en   = 1'b1;
			rd_addr = i[`CNN_ADDR_WIDTH-1:0];
			exp_q.push_back(expect_fm[i]);
			addr_q.push_back(i);
			@(negedge clk);
		end
		rd_en = 1'b0;
		@(negedge clk);
		@(negedge clk);
	endtask

	task automatic report_test(input int num, input string name);
		tests_run++;
		if (errors == err_start) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", num, name, errors - err_start);
		end
	endtask

	// Registered read data of a read seen at a rising edge is checked at the next fall
	always @(posedge clk) begin
		rd_seen <= rd_en;
	end

	always @(negedge clk) begin
		if (rd_seen) begin
			exp_word = exp_q.pop_front();
			exp_addr = addr_q.pop_front();
			if (rd_data !== exp_word) begin
				$display("mismatch at %0t: address %0d read %h, expected %h",
					$time, exp_addr, rd_data, exp_word);
				errors++;
			end
		end
	end

	initial begin
		seed         = 32'hd80f_adf3;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		exp_bank     = 1'b0;
		last_num     = 0;
		rst          = 1'b0;
		layer_type   = cnn_layer_pkg::FINISH;
		layer_num    = '0;
		fm_size      = '0;
		pool_k       = '0;
		init_we      = 1'b0;
		init_addr    = '0;
		init_data    = '0;
		init_done    = 1'b0;
		rd_en        = 1'b0;
		rd_addr      = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);

		// Reset levels then host load of an 8 x 8 map
		err_start = errors;
		if (init_fm_ram_ready !== 1'b0 || layer_ready !== 1'b0 || fm_bank !== 1'b0) begin
			$display("mismatch at %0t: status after reset is %b%b%b, expected 000",
				$time, init_fm_ram_ready, layer_ready, fm_bank);
			errors++;
		end
		load_fm(8);
		report_test(1, "init load");

		err_start = errors;
		run_pool(1, 8, 2);
		readback(16);
		report_test(2, "pool 8x8 k2");

		// Runs on the previous output half
		err_start = errors;
		run_pool(2, 4, 2);
		readback(4);
		report_test(3, "chained pool 4x4 k2");

		err_start = errors;
		load_fm(7);
		run_pool(3, 7, 3);
		readback(4);
		// Same layer number again must not start a run
		layer_num = 4'd3;
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			if (layer_ready !== 1'b1 || fm_bank !== exp_bank) begin
				$display("mismatch at %0t: repeated layer number changed status", $time);
				errors++;
			end
		end
		readback(4);
		report_test(4, "pool 7x7 k3 and repeat");

		err_start = errors;
		layer_type = cnn_layer_pkg::FINISH;
		wait_status(1, 1'b0, "layer_ready_o to drop on finish");
		if (fm_bank !== exp_bank) begin
			$display("mismatch at %0t: fm_bank_o changed on finish", $time);
			errors++;
		end
		readback(4);
		report_test(5, "finish");

		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== hdl/cnn_pool_layer.sv ====
`timescale 1ns/1ps

`include "cnn_params.svh"

module cnn_pool_layer (
	input  logic                             clk,
	input  logic                             rst,
	// Layer control
	input  cnn_layer_pkg::layer_type_e       layer_type_i,
	input  logic [`CNN_LAYER_NUM_WIDTH-1:0]  layer_num_i,
	input  logic [`CNN_FM_SIZE_WIDTH-1:0]    fm_size_i,
	input  logic [`CNN_POOL_SIZE_WIDTH-1:0]  pool_win_size_i,
	// Host load into the current half
	input  logic                             init_we_i,
	input  logic [`CNN_ADDR_WIDTH-1:0]       init_addr_i,
	input  fp16_pkg::fp16_lanes_t            init_data_i,
	input  logic                             init_done_i,
	// Readback, one cycle latency
	input  logic                             rd_en_i,
	input  logic [`CNN_ADDR_WIDTH-1:0]       rd_addr_i,
	output fp16_pkg::fp16_lanes_t            rd_data_o,
	// Status
	output logic                             init_fm_ram_ready_o,
	output logic                             layer_ready_o,
	output logic                             fm_bank_o
);

	logic                       start;
	logic                       step;
	logic                       pool_rd;
	logic                       pool_first;
	logic                       pool_last;
	logic                       win_last;
	logic                       all_last;
	logic                       result_valid;
	logic [`CNN_ADDR_WIDTH-1:0] pool_raddr;
	logic [`CNN_ADDR_WIDTH-1:0] pool_waddr;
	fp16_pkg::fp16_lanes_t      pool_result;

	pool_layer_ctrl u_pool_layer_ctrl (
		.clk                 (clk),
		.rst                 (rst),
		.layer_type_i        (layer_type_i),
		.layer_num_i         (layer_num_i),
		.init_done_i         (init_done_i),
		.win_last_i          (win_last),
		.all_last_i          (all_last),
		.result_valid_i      (result_valid),
		.start_o             (start),
		.step_o              (step),
		.rd_o                (pool_rd),
		.first_o             (pool_first),
		.last_o              (pool_last),
		.bank_o              (fm_bank_o),
		.init_fm_ram_ready_o (init_fm_ram_ready_o),
		.layer_ready_o       (layer_ready_o)
	);

	// Result pulse also moves the output address
	pool_window_counter u_pool_window_counter (
		.clk             (clk),
		.rst             (rst),
		.start_i         (start),
		.step_i          (step),
		.wr_step_i       (result_valid),
		.fm_size_i       (fm_size_i),
		.pool_win_size_i (pool_win_size_i),
		.rd_addr_o       (pool_raddr),
		.wr_addr_o       (pool_waddr),
		.win_last_o      (win_last),
		.all_last_o      (all_last)
	);

	fm_pingpong_ram u_fm_pingpong_ram (
		.clk          (clk),
		.bank_i       (fm_bank_o),
		.host_we_i    (init_we_i),
		.host_addr_i  (init_addr_i),
		.host_data_i  (init_data_i),
		.host_re_i    (rd_en_i),
		.host_raddr_i (rd_addr_i),
		.pool_re_i    (pool_rd),
		.pool_raddr_i (pool_raddr),
		.pool_we_i    (result_valid),
		.pool_waddr_i (pool_waddr),
		.pool_wdata_i (pool_result),
		.rdata_o      (rd_data_o)
	);

	// Shared read data feeds both the host and the lanes
	max_pool_lanes u_max_pool_lanes (
		.clk            (clk),
		.rst            (rst),
		.rd_i           (pool_rd),
		.first_i        (pool_first),
		.last_i         (pool_last),
		.data_i         (rd_data_o),
		.result_valid_o (result_valid),
		.result_o       (pool_result)
	);

endmodule

// ==== hdl/max_pool_lanes.sv ====
`timescale 1ns/1ps

`include "cnn_params.svh"

module max_pool_lanes (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  rd_i,
	input  logic                  first_i,
	input  logic                  last_i,
	input  fp16_pkg::fp16_lanes_t data_i,
	output logic                  result_valid_o,
	output fp16_pkg::fp16_lanes_t result_o
);

	// Strobes delayed to meet the registered RAM output
	logic rd_q;
	logic first_q;
	logic last_q;

	// a above b in float16 order, -0 sits below +0
	function automatic logic fp16_gt(input fp16_pkg::fp16_t a, input fp16_pkg::fp16_t b);
		if (a[15] != b[15]) begin
			return ~a[15];
		end else if (!a[15]) begin
			return a[14:0] > b[14:0];
		end else begin
			// Both negative, smaller magnitude is larger
			return a[14:0] < b[14:0];
		end
	endfunction

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_q           <= 1'b0;
			first_q        <= 1'b0;
			last_q         <= 1'b0;
			result_valid_o <= 1'b0;
			result_o       <= {`CNN_PARA_Y{fp16_pkg::FP16_LOWEST}};
		end else begin
			rd_q           <= rd_i;
			first_q        <= first_i;
			last_q         <= last_i;
			// Pulse in the cycle the final maxima are held
			result_valid_o <= rd_q & last_q;
			if (rd_q) begin
				for (int j = 0; j < `CNN_PARA_Y; j++) begin
					// First word of a window restarts the lane
					if (first_q || fp16_gt(data_i[j], result_o[j])) begin
						result_o[j] <= data_i[j];
					end
				end
			end
		end
	end

endmodule

// ==== hdl/fm_pingpong_ram.sv ====
`timescale 1ns/1ps

`include "cnn_params.svh"

module fm_pingpong_ram (
	input  logic                        clk,
	input  logic                        bank_i,
	input  logic                        host_we_i,
	input  logic [`CNN_ADDR_WIDTH-1:0]  host_addr_i,
	input  fp16_pkg::fp16_lanes_t       host_data_i,
	input  logic                        host_re_i,
	input  logic [`CNN_ADDR_WIDTH-1:0]  host_raddr_i,
	input  logic                        pool_re_i,
	input  logic [`CNN_ADDR_WIDTH-1:0]  pool_raddr_i,
	input  logic                        pool_we_i,
	input  logic [`CNN_ADDR_WIDTH-1:0]  pool_waddr_i,
	input  fp16_pkg::fp16_lanes_t       pool_wdata_i,
	output fp16_pkg::fp16_lanes_t       rdata_o
);

	// Bank bit on top selects the half
	fp16_pkg::fp16_lanes_t mem [0:2*`CNN_FM_RAM_HALF-1];

	logic [`CNN_ADDR_WIDTH:0] waddr;
	logic [`CNN_ADDR_WIDTH:0] raddr;
	fp16_pkg::fp16_lanes_t    wdata;

	// Write port, pool results go to the half not being read
	assign waddr = pool_we_i ? {~bank_i, pool_waddr_i} : {bank_i, host_addr_i};
	assign wdata = pool_we_i ? pool_wdata_i : host_data_i;

	// Read port, host only reads while the pool engine is idle
	assign raddr = pool_re_i ? {bank_i, pool_raddr_i} : {bank_i, host_raddr_i};

	always_ff @(posedge clk) begin
		if (pool_we_i || host_we_i) begin
			mem[waddr] <= wdata;
		end
		if (pool_re_i || host_re_i) begin
			rdata_o <= mem[raddr];
		end
	end

endmodule

// ==== hdl/pool_window_counter.sv ====
`timescale 1ns/1ps

`include "cnn_params.svh"

module pool_window_counter (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             start_i,
	input  logic                             step_i,
	input  logic                             wr_step_i,
	input  logic [`CNN_FM_SIZE_WIDTH-1:0]    fm_size_i,
	input  logic [`CNN_POOL_SIZE_WIDTH-1:0]  pool_win_size_i,
	output logic [`CNN_ADDR_WIDTH-1:0]       rd_addr_o,
	output logic [`CNN_ADDR_WIDTH-1:0]       wr_addr_o,
	output logic                             win_last_o,
	output logic                             all_last_o
);

	// Window origin
	logic [`CNN_FM_SIZE_WIDTH-1:0] win_row_q;
	logic [`CNN_FM_SIZE_WIDTH-1:0] win_col_q;
	// Position inside the window
	logic [`CNN_FM_SIZE_WIDTH-1:0] in_row_q;
	logic [`CNN_FM_SIZE_WIDTH-1:0] in_col_q;
	// Linear output index, one per finished window
	logic [`CNN_ADDR_WIDTH-1:0]    wr_idx_q;

	logic [`CNN_FM_SIZE_WIDTH-1:0]   k_ext;
	logic [`CNN_FM_SIZE_WIDTH-1:0]   k_m1;
	logic                            in_last_col;
	logic                            in_last_row;
	logic                            col_next_fits;
	logic                            row_next_fits;
	logic [`CNN_FM_SIZE_WIDTH-1:0]   row_abs;
	logic [`CNN_FM_SIZE_WIDTH-1:0]   col_abs;
	logic [2*`CNN_FM_SIZE_WIDTH-1:0] rd_offset;

	assign k_ext = {{(`CNN_FM_SIZE_WIDTH-`CNN_POOL_SIZE_WIDTH){1'b0}}, pool_win_size_i};
	assign k_m1  = k_ext - 1'b1;

	assign in_last_col = (in_col_q == k_m1);
	assign in_last_row = (in_row_q == k_m1);

	// Next window must end inside the map, partial windows are dropped
	assign col_next_fits = ({1'b0, win_col_q} + {k_ext, 1'b0}) <= {1'b0, fm_size_i};
	assign row_next_fits = ({1'b0, win_row_q} + {k_ext, 1'b0}) <= {1'b0, fm_size_i};

	assign win_last_o = in_last_col & in_last_row;
	assign all_last_o = ~col_next_fits & ~row_next_fits;

	// Row-major word offset within the input half
	assign row_abs   = win_row_q + in_row_q;
	assign col_abs   = win_col_q + in_col_q;
	assign rd_offset = row_abs * fm_size_i + col_abs;
	assign rd_addr_o = rd_offset[`CNN_ADDR_WIDTH-1:0];

	assign wr_addr_o = wr_idx_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			win_row_q <= '0;
			win_col_q <= '0;
			in_row_q  <= '0;
			in_col_q  <= '0;
			wr_idx_q  <= '0;
		end else if (start_i) begin
			win_row_q <= '0;
			win_col_q <= '0;
			in_row_q  <= '0;
			in_col_q  <= '0;
			wr_idx_q  <= '0;
		end else begin
			if (step_i) begin
				if (!in_last_col) begin
					in_col_q <= in_col_q + 1'b1;
				end else begin
					in_col_q <= '0;
					if (!in_last_row) begin
						in_row_q <= in_row_q + 1'b1;
					end else begin
						// Window done, move along the row first
						in_row_q <= '0;
						if (col_next_fits) begin
							win_col_q <= win_col_q + k_ext;
						end else begin
							win_col_q <= '0;
							if (row_next_fits) begin
								win_row_q <= win_row_q + k_ext;
							end
						end
					end
				end
			end
			// Output address follows the result stream
			if (wr_step_i) begin
				wr_idx_q <= wr_idx_q + 1'b1;
			end
		end
	end

endmodule

// ==== hdl/pool_layer_ctrl.sv ====
`timescale 1ns/1ps

`include "cnn_params.svh"

module pool_layer_ctrl (
	input  logic                             clk,
	input  logic                             rst,
	input  cnn_layer_pkg::layer_type_e       layer_type_i,
	input  logic [`CNN_LAYER_NUM_WIDTH-1:0]  layer_num_i,
	input  logic                             init_done_i,
	input  logic                             win_last_i,
	input  logic                             all_last_i,
	input  logic                             result_valid_i,
	output logic                             start_o,
	output logic                             step_o,
	output logic                             rd_o,
	output logic                             first_o,
	output logic                             last_o,
	output logic                             bank_o,
	output logic                             init_fm_ram_ready_o,
	output logic                             layer_ready_o
);

	cnn_layer_pkg::ctrl_state_e state_q;

	// Last layer number that started a run
	logic [`CNN_LAYER_NUM_WIDTH-1:0] layer_num_q;

	// Next read opens a window
	logic first_q;

	// Set one cycle into DRAIN, the final result arrives after that
	logic drain_wait_q;

	logic pool_req;

	// New pool layer, only once the input half is loaded
	assign pool_req = (state_q == cnn_layer_pkg::IDLE) &&
	                  (layer_type_i == cnn_layer_pkg::POOL) &&
	                  init_fm_ram_ready_o &&
	                  (layer_num_i != layer_num_q);

	// Counter restarts on the same edge the FSM enters READ
	assign start_o = pool_req;

	// One read per cycle for the whole run, no stalls
	assign rd_o   = (state_q == cnn_layer_pkg::READ);
	assign step_o = rd_o;

	// Window boundary flags travel with the read
	assign first_o = rd_o & first_q;
	assign last_o  = rd_o & win_last_i;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q             <= cnn_layer_pkg::IDLE;
			layer_num_q         <= '0;
			first_q             <= 1'b0;
			drain_wait_q        <= 1'b0;
			bank_o              <= 1'b0;
			init_fm_ram_ready_o <= 1'b0;
			layer_ready_o       <= 1'b0;
		end else begin
			case (state_q)
				cnn_layer_pkg::IDLE: begin
					if (layer_type_i == cnn_layer_pkg::INIT) begin
						// Fresh load, ready levels start low again
						init_fm_ram_ready_o <= 1'b0;
						layer_ready_o       <= 1'b0;
						state_q             <= cnn_layer_pkg::LOAD;
					end else if (layer_type_i == cnn_layer_pkg::FINISH) begin
						// Bank and RAM contents stay for readback
						layer_ready_o <= 1'b0;
					end else if (pool_req) begin
						layer_num_q   <= layer_num_i;
						layer_ready_o <= 1'b0;
						first_q       <= 1'b1;
						state_q       <= cnn_layer_pkg::READ;
					end
				end
				cnn_layer_pkg::LOAD: begin
					if (init_done_i) begin
						init_fm_ram_ready_o <= 1'b1;
					end
					// Layer ready trails the RAM ready by one edge
					if (init_fm_ram_ready_o) begin
						layer_ready_o <= 1'b1;
					end
					if (layer_type_i != cnn_layer_pkg::INIT) begin
						state_q <= cnn_layer_pkg::IDLE;
					end
				end
				cnn_layer_pkg::READ: begin
					// Read after a window's last one opens the next window
					first_q <= win_last_i;
					if (win_last_i && all_last_i) begin
						drain_wait_q <= 1'b0;
						state_q      <= cnn_layer_pkg::DRAIN;
					end
				end
				cnn_layer_pkg::DRAIN: begin
					drain_wait_q <= 1'b1;
					// For k=1 the previous window's result lands in the first DRAIN cycle
					if (result_valid_i && drain_wait_q) begin
						// Output half becomes the next layer's input
						bank_o  <= ~bank_o;
						state_q <= cnn_layer_pkg::DONE;
					end
				end
				cnn_layer_pkg::DONE: begin
					layer_ready_o <= 1'b1;
					state_q       <= cnn_layer_pkg::IDLE;
				end
				default: begin
					state_q <= cnn_layer_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

// ==== hdl/fp16_pkg.sv ====
`include "cnn_params.svh"

package fp16_pkg;

	// Raw half-precision word
	// Bit 15 sign, 14:10 exponent, 9:0 mantissa
	typedef logic [`CNN_DATA_WIDTH-1:0] fp16_t;

	// One RAM word, lane j is slice j
	typedef fp16_t [`CNN_PARA_Y-1:0] fp16_lanes_t;

	// Negative infinity, below every finite value
	localparam fp16_t FP16_LOWEST = 16'hfc00;

endpackage

// ==== hdl/cnn_layer_pkg.sv ====
package cnn_layer_pkg;

	// Layer type seen on the host control port
	// Encodings follow the wider accelerator, 1 and 3 were conv and fc
	typedef enum logic [3:0] {
		INIT   = 4'd0,
		POOL   = 4'd2,
		FINISH = 4'd9
	} layer_type_e;

	// Sequencer states
	typedef enum logic [2:0] {
		// Waiting for a new layer request
		IDLE,
		// Host filling the input half
		LOAD,
		// One window read per k*k cycles, back to back
		READ,
		// Last reads issued, results still in the max lanes
		DRAIN,
		// Bank flipped, raise layer ready
		DONE
	} ctrl_state_e;

endpackage

// ==== include/cnn_params.svh ====
`ifndef CNN_PARAMS_SVH
`define CNN_PARAMS_SVH

// One half-precision value
`define CNN_DATA_WIDTH 16

// Parallel lanes per RAM word, one feature map slice per lane
`define CNN_PARA_Y 4

// Full RAM word, all lanes packed
`define CNN_LANES_WIDTH (`CNN_DATA_WIDTH * `CNN_PARA_Y)

// Words in one ping-pong half
`define CNN_FM_RAM_HALF 256

// Word address inside one half
`define CNN_ADDR_WIDTH 8

// Side length of a square feature map
`define CNN_FM_SIZE_WIDTH 5

// Pool window side, 1 to 3
`define CNN_POOL_SIZE_WIDTH 2
`define CNN_LAYER_NUM_WIDTH 4

`endif
